/* verilog/fetch_pkg.sv */
package fetch_pkg;

   // instruction and pc width
   localparam int inst_w   = 16;
   // slots fetched per cycle
   localparam int bundle_n = 4;

   typedef logic [inst_w-1:0]   inst_t;
   // bit i belongs to slot i, slot 0 is inst0 and the oldest
   typedef logic [bundle_n-1:0] slot_mask_t;

   //////////////////////////////////////////////////////////////////////
   // opcode rules
   //////////////////////////////////////////////////////////////////////

   // top nibble all ones
   function automatic logic is_jump(inst_t ins);
      return &ins[15:12];
   endfunction

   // jump with a zero register field in bits 1..0
   function automatic logic is_im_jump(inst_t ins);
      return is_jump(ins) && (ins[1:0] == 2'b00);
   endfunction

   // 10xx with xx nonzero
   function automatic logic is_branch(inst_t ins);
      return (ins[15:14] == 2'b10) && (ins[13:12] != 2'b00);
   endfunction

   // sign extended bits 7..0
   function automatic inst_t branch_offset(inst_t ins);
      return {{(inst_w - 8){ins[7]}}, ins[7:0]};
   endfunction

   // sign extended bits 11..2
   function automatic inst_t jump_offset(inst_t ins);
      return {{(inst_w - 10){ins[11]}}, ins[11:2]};
   endfunction

endpackage

/* verilog/bpred_pkg.sv */
package bpred_pkg;

   // 2-bit saturating counter
   typedef logic [1:0] bpred_ctr_t;

   // weakly not taken
   localparam bpred_ctr_t bpred_ctr_init = 2'd1;

   // table index taken from the low pc bits
   localparam int bpred_idx_w = 4;

   // branches allowed in flight past fetch
   localparam int max_branches = 2;

   // upper half of the range predicts taken
   function automatic logic ctr_taken(bpred_ctr_t c);
      return c[1];
   endfunction

   // saturate at 0 and 3
   function automatic bpred_ctr_t ctr_train(bpred_ctr_t c, logic taken);
      bpred_ctr_t r;
      r = c;
      if (taken && (c != 2'd3))
         r = c + 2'd1;
      else if (!taken && (c != 2'd0))
         r = c - 2'd1;
      return r;
   endfunction

endpackage

/* verilog/fetch_bundle_if.sv */
interface fetch_bundle_if import fetch_pkg::*; ();

   // pc of slot 0
   logic [inst_w-1:0] pc;

   // raw words from instruction memory
   inst_t inst [bundle_n];

   // low only while the core sits in reset
   logic valid;

   // pc unit owns the pc and reads the words for target math
   modport source (
      output pc,
      input  inst
   );

   // filter and predictor only look
   modport sink (
      input pc,
      input inst,
      input valid
   );

endinterface

/* verilog/resolve_if.sv */
interface resolve_if import fetch_pkg::*; ();

   // single cycle pulse from commit
   logic              valid;
   // pc of the resolved branch
   logic [inst_w-1:0] pc;
   logic              taken;
   logic              mispredict;
   // younger in-flight branch thrown away too
   logic              two_branches;
   // correct fetch pc after a mispredict
   logic [inst_w-1:0] target;

   modport commit (
      output valid, pc, taken, mispredict, two_branches, target
   );

   modport listener (
      input valid, pc, taken, mispredict, two_branches, target
   );

endinterface

/* verilog/bundle_filter.sv */
module bundle_filter import fetch_pkg::*, bpred_pkg::*; #(
   parameter int max_inflight = max_branches
) (
   input  logic              clk,
   input  logic              rst_n,
   fetch_bundle_if.sink      bundle,
   resolve_if.listener       resolve,
   input  logic              stall_fetch,
   input  logic [1:0]        pred,
   output slot_mask_t        branch_mask,
   output slot_mask_t        tkn_brnch,
   output slot_mask_t        is_im_jmp,
   output logic              redirect,
   output logic [inst_w-1:0] seq_pc,
   output inst_t             instruction0,
   output inst_t             instruction1,
   output inst_t             instruction2,
   output inst_t             instruction3,
   output logic              brch_full
);

   // counter never passes the limit
   localparam int cnt_w = $clog2(max_inflight + 1);

   slot_mask_t       is_jmp;
   slot_mask_t       is_imj;
   slot_mask_t       squash;
   slot_mask_t       hit;
   slot_mask_t       live_br;
   logic [cnt_w-1:0] brnch_cnt;
   logic [cnt_w-1:0] brnch_cnt_nxt;
   logic             hold_q;
   logic             block;

   //////////////////////////////////////////////////////////////////////
   // slot decode
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < bundle_n; i++) begin
         branch_mask[i] = is_branch(bundle.inst[i]);
         is_jmp[i]      = is_jump(bundle.inst[i]);
         is_imj[i]      = is_im_jump(bundle.inst[i]);
      end
   end

   // whole bundle dropped
   assign block = stall_fetch || hold_q || !bundle.valid;

   //////////////////////////////////////////////////////////////////////
   // squash chain, oldest slot first
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      int   run;
      int   ord;
      logic cut;
      logic p;
      // branches already in flight
      run = int'(brnch_cnt);
      // branches seen so far in this bundle
      ord = 0;
      cut = block;
      for (int i = 0; i < bundle_n; i++) begin
         run = run + int'(branch_mask[i]);
         // first branch gets pred[1], second gets pred[0]
         if (ord == 0)
            p = pred[1];
         else if (ord == 1)
            p = pred[0];
         else
            p = 1'b0;
         // third branch reached with nothing older cutting the bundle
         hit[i]       = branch_mask[i] && (run > max_inflight) && !cut;
         squash[i]    = cut || (branch_mask[i] && (run > max_inflight));
         tkn_brnch[i] = branch_mask[i] && !squash[i] && p;
         ord          = ord + int'(branch_mask[i]);
         // everything younger than a jump or a taken branch goes
         cut          = squash[i] || is_jmp[i] || tkn_brnch[i];
      end
   end

   assign is_im_jmp = is_imj & ~squash;
   assign live_br   = branch_mask & ~squash;

   // bundle ends on a live jump or taken branch
   assign redirect = |((is_jmp | tkn_brnch) & ~squash);

   // pc of the oldest squashed slot, else the next bundle
   always_comb begin
      seq_pc = bundle.pc + inst_w'(bundle_n);
      for (int i = bundle_n - 1; i >= 0; i--) begin
         if (squash[i])
            seq_pc = bundle.pc + inst_w'(i);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // outstanding branch count and hold
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      int base;
      int inc;
      base = int'(brnch_cnt);
      // zero under a stall since every slot is squashed
      inc  = $countones(live_br);
      if (resolve.valid) begin
         base = resolve.two_branches ? base - 2 : base - 1;
         if (base < 0)
            base = 0;
      end
      brnch_cnt_nxt = cnt_w'(base + inc);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         brnch_cnt <= '0;
         hold_q    <= 1'b0;
      end else begin
         brnch_cnt <= brnch_cnt_nxt;
         // any resolve frees a slot for the held branch
         if (resolve.valid)
            hold_q <= 1'b0;
         else if (|hit)
            hold_q <= 1'b1;
      end
   end

   // up in the cycle the third branch shows, then held
   assign brch_full = hold_q || (|hit);

   // squashed slots become nops
   assign instruction0 = squash[0] ? '0 : bundle.inst[0];
   assign instruction1 = squash[1] ? '0 : bundle.inst[1];
   assign instruction2 = squash[2] ? '0 : bundle.inst[2];
   assign instruction3 = squash[3] ? '0 : bundle.inst[3];

endmodule

/* verilog/branch_predictor.sv */
module branch_predictor import fetch_pkg::*, bpred_pkg::*; #(
   parameter int bpred_entries = 16
) (
   input  logic         clk,
   input  logic         rst_n,
   fetch_bundle_if.sink bundle,
   resolve_if.listener  resolve,
   input  slot_mask_t   branch_mask,
   output logic [1:0]   pred
);

   bpred_ctr_t             ctr_tbl [bpred_entries];
   logic [bpred_idx_w-1:0] look_idx [2];
   logic [1:0]             look_hit;
   logic [bpred_idx_w-1:0] train_idx;

   //////////////////////////////////////////////////////////////////////
   // lookup for the two oldest branches
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      int                n;
      logic [inst_w-1:0] slot_pc;
      n           = 0;
      look_hit    = '0;
      look_idx[0] = '0;
      look_idx[1] = '0;
      for (int i = 0; i < bundle_n; i++) begin
         slot_pc = bundle.pc + inst_w'(i);
         if (branch_mask[i] && (n < 2)) begin
            look_idx[n] = slot_pc[bpred_idx_w-1:0];
            look_hit[n] = 1'b1;
            n           = n + 1;
         end
      end
   end

   // bit 1 for the first branch, bit 0 for the second
   assign pred[1] = bundle.valid && look_hit[0] && ctr_taken(ctr_tbl[look_idx[0]]);
   assign pred[0] = bundle.valid && look_hit[1] && ctr_taken(ctr_tbl[look_idx[1]]);

   //////////////////////////////////////////////////////////////////////
   // training from commit
   //////////////////////////////////////////////////////////////////////

   assign train_idx = resolve.pc[bpred_idx_w-1:0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int e = 0; e < bpred_entries; e++) begin
            ctr_tbl[e] <= bpred_ctr_init;
         end
      end else if (resolve.valid) begin
         // up on taken, down otherwise
         ctr_tbl[train_idx] <= ctr_train(ctr_tbl[train_idx], resolve.taken);
      end
   end

endmodule

/* verilog/fetch_pc_unit.sv */
module fetch_pc_unit import fetch_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   fetch_bundle_if.source    bundle,
   resolve_if.listener       resolve,
   input  logic              stall_fetch,
   input  logic              stall_for_jump,
   input  slot_mask_t        tkn_brnch,
   input  slot_mask_t        is_im_jmp,
   input  logic              redirect,
   input  logic [inst_w-1:0] seq_pc,
   input  logic [1:0]        pred,
   output logic              flush_mem
);

   logic [inst_w-1:0] pc_q;
   logic [inst_w-1:0] pc_nxt;
   logic [inst_w-1:0] ctl_target;
   logic [inst_w-1:0] br_tgt  [bundle_n];
   logic [inst_w-1:0] jmp_tgt [bundle_n];

   assign bundle.pc = pc_q;

   //////////////////////////////////////////////////////////////////////
   // per slot targets
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      logic [inst_w-1:0] slot_pc;
      for (int i = 0; i < bundle_n; i++) begin
         slot_pc    = pc_q + inst_w'(i);
         br_tgt[i]  = slot_pc + branch_offset(bundle.inst[i]);
         jmp_tgt[i] = slot_pc + jump_offset(bundle.inst[i]);
      end
   end

   // oldest taken branch beats oldest immediate jump
   always_comb begin
      // register jump keeps seq_pc and waits on stall_for_jump
      ctl_target = seq_pc;
      for (int i = bundle_n - 1; i >= 0; i--) begin
         if (is_im_jmp[i])
            ctl_target = jmp_tgt[i];
      end
      for (int i = bundle_n - 1; i >= 0; i--) begin
         if (tkn_brnch[i])
            ctl_target = br_tgt[i];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // next pc select
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      if (resolve.valid && resolve.mispredict)
         pc_nxt = resolve.target;
      else if (stall_fetch || stall_for_jump)
         pc_nxt = pc_q;
      else if (redirect)
         pc_nxt = ctl_target;
      else
         pc_nxt = seq_pc;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q      <= '0;
         flush_mem <= 1'b0;
      end else begin
         pc_q      <= pc_nxt;
         // memory drops its in-flight fetch one cycle later
         flush_mem <= (|pred) || (resolve.valid && resolve.mispredict);
      end
   end

endmodule

/* verilog/fetch_front_end.sv */
module fetch_front_end import fetch_pkg::*, bpred_pkg::*; #(
   parameter int bpred_entries = 16,
   parameter int max_inflight  = max_branches
) (
   input  logic                clk,
   input  logic                rst_n,
   output logic [inst_w-1:0]   fetch_pc,
   input  logic [inst_w-1:0]   inst0,
   input  logic [inst_w-1:0]   inst1,
   input  logic [inst_w-1:0]   inst2,
   input  logic [inst_w-1:0]   inst3,
   input  logic                stall_fetch,
   input  logic                stall_for_jump,
   input  logic                resolve_valid,
   input  logic                resolve_taken,
   input  logic                resolve_mispredict,
   input  logic                resolve_two,
   input  logic [inst_w-1:0]   resolve_pc,
   input  logic [inst_w-1:0]   resolve_target,
   output logic [inst_w-1:0]   instruction0,
   output logic [inst_w-1:0]   instruction1,
   output logic [inst_w-1:0]   instruction2,
   output logic [inst_w-1:0]   instruction3,
   output logic [bundle_n-1:0] tkn_brnch,
   output logic [bundle_n-1:0] is_im_jmp,
   output logic                brch_full,
   output logic                flush_mem
);

   fetch_bundle_if bundle ();
   resolve_if      resolve ();

   slot_mask_t        branch_mask;
   logic [1:0]        pred;
   logic              redirect;
   logic [inst_w-1:0] seq_pc;

   // memory words into the bundle
   assign bundle.inst[0] = inst0;
   assign bundle.inst[1] = inst1;
   assign bundle.inst[2] = inst2;
   assign bundle.inst[3] = inst3;
   assign bundle.valid   = rst_n;
   assign fetch_pc       = bundle.pc;

   // commit side of the resolve message
   assign resolve.valid        = resolve_valid;
   assign resolve.pc           = resolve_pc;
   assign resolve.taken        = resolve_taken;
   assign resolve.mispredict   = resolve_mispredict;
   assign resolve.two_branches = resolve_two;
   assign resolve.target       = resolve_target;

   fetch_pc_unit u_pc (
      .clk, .rst_n, .bundle(bundle.source), .resolve(resolve.listener),
      .stall_fetch, .stall_for_jump, .tkn_brnch, .is_im_jmp,
      .redirect, .seq_pc, .pred, .flush_mem
   );

   bundle_filter #(.max_inflight(max_inflight)) u_filter (
      .clk, .rst_n, .bundle(bundle.sink), .resolve(resolve.listener),
      .stall_fetch, .pred, .branch_mask, .tkn_brnch, .is_im_jmp,
      .redirect, .seq_pc, .instruction0, .instruction1,
      .instruction2, .instruction3, .brch_full
   );

   branch_predictor #(.bpred_entries(bpred_entries)) u_bpred (
      .clk, .rst_n, .bundle(bundle.sink), .resolve(resolve.listener),
      .branch_mask, .pred
   );

endmodule

/* sim/tb_fetch_front_end.sv */
module tb_fetch_front_end;

   // control bits of a table row
   localparam logic [5:0] c_none  = 6'b000000;
   localparam logic [5:0] c_stall = 6'b100000;
   localparam logic [5:0] c_jwait = 6'b010000;
   localparam logic [5:0] c_res   = 6'b001000;
   localparam logic [5:0] c_tkn   = 6'b000100;
   localparam logic [5:0] c_mis   = 6'b000010;
   localparam logic [5:0] c_two   = 6'b000001;
   // zero slot in the table becomes random filler
   localparam logic [15:0] fill = 16'h0000;
   localparam int branch_limit = 2;
   localparam int reset_cycles = 10;

   typedef struct packed {
      logic [3:0][15:0] inst;
      logic [5:0]       ctl;
      logic [15:0]      rpc;
      logic [15:0]      rtgt;
   } row_t;

   logic        clk;
   logic        rst_n;
   logic [15:0] fetch_pc;
   logic [15:0] inst0;
   logic [15:0] inst1;
   logic [15:0] inst2;
   logic [15:0] inst3;
   logic        stall_fetch;
   logic        stall_for_jump;
   logic        resolve_valid;
   logic        resolve_taken;
   logic        resolve_mispredict;
   logic        resolve_two;
   logic [15:0] resolve_pc;
   logic [15:0] resolve_target;
   logic [15:0] instruction0;
   logic [15:0] instruction1;
   logic [15:0] instruction2;
   logic [15:0] instruction3;
   logic [3:0]  tkn_brnch;
   logic [3:0]  is_im_jmp;
   logic        brch_full;
   logic        flush_mem;

   row_t        rows[$];
   int          errors;
   int          checks;
   int          cycles;
   int          cycle_limit;
   logic [31:0] seed;

   // model state
   logic [15:0]      m_pc;
   int               m_cnt;
   logic             m_hold;
   logic             m_flush;
   logic [1:0]       m_ctr [16];
   // expected bundle outputs
   logic [3:0][15:0] e_inst;
   logic [3:0]       e_tkn;
   logic [3:0]       e_imj;
   logic             e_full;

   fetch_front_end UUT (.*);

   always #2 clk = ~clk;

   // run limit
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout, the run went past %0d cycles", cycle_limit);
         $display(">>> FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // decode rules and helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // top bit clear, never a branch or jump
   function automatic logic [15:0] filler();
      seed = xorshift32(seed);
      return {1'b0, seed[14:0]};
   endfunction

   function automatic logic branch_op(input logic [15:0] w);
      return (w[15:14] == 2'b10) && (w[13:12] != 2'b00);
   endfunction

   function automatic logic jump_op(input logic [15:0] w);
      return w[15:12] == 4'hf;
   endfunction

   function automatic logic [15:0] br_disp(input logic [15:0] w);
      return {{8{w[7]}}, w[7:0]};
   endfunction

   function automatic logic [15:0] jmp_disp(input logic [15:0] w);
      return {{6{w[11]}}, w[11:2]};
   endfunction

   task automatic add_row(input logic [15:0] s0, input logic [15:0] s1,
                          input logic [15:0] s2, input logic [15:0] s3,
                          input logic [5:0] ctl, input logic [15:0] rpc,
                          input logic [15:0] rtgt);
      row_t r;
      r.inst[0] = s0;
      r.inst[1] = s1;
      r.inst[2] = s2;
      r.inst[3] = s3;
      r.ctl     = ctl;
      r.rpc     = rpc;
      r.rtgt    = rtgt;
      rows.push_back(r);
   endtask

   task automatic compare(input string name, input logic [15:0] got,
                          input logic [15:0] exp);
      checks = checks + 1;
      if (got !== exp) begin
         errors = errors + 1;
         $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_regs();
      compare("fetch_pc", fetch_pc, m_pc);
      compare("flush_mem", 16'(flush_mem), 16'(m_flush));
   endtask

   //////////////////////////////////////////////////////////////////////
   // reference model, one bundle per call
   //////////////////////////////////////////////////////////////////////

   task automatic model_step(input row_t r, input logic [3:0][15:0] ins);
      int          stop;
      int          nbr;
      int          live;
      int          base;
      logic        over;
      logic        any_pred;
      logic        pt;
      logic        redir;
      logic [15:0] spc;
      logic [15:0] tgt;
      logic [15:0] nxt;
      logic [3:0]  idx;
      // first squashed slot, 4 when none
      stop     = (r.ctl[5] || m_hold) ? 0 : 4;
      nbr      = 0;
      live     = 0;
      over     = 1'b0;
      any_pred = 1'b0;
      redir    = 1'b0;
      tgt      = 16'h0;
      e_tkn    = 4'h0;
      e_imj    = 4'h0;
      for (int i = 0; i < 4; i++) begin
         spc = m_pc + 16'(i);
         // predictor sees the two oldest branches even when squashed
         pt       = branch_op(ins[i]) && (nbr < 2) && m_ctr[spc[3:0]][1];
         any_pred = any_pred | pt;
         if (branch_op(ins[i]))
            nbr = nbr + 1;
         if (i < stop) begin
            if (branch_op(ins[i]) && (m_cnt + nbr > branch_limit)) begin
               // third branch, bundle ends just before it
               stop = i;
               over = 1'b1;
            end else if (pt) begin
               stop     = i + 1;
               e_tkn[i] = 1'b1;
               redir    = 1'b1;
               tgt      = spc + br_disp(ins[i]);
            end else if (jump_op(ins[i])) begin
               stop  = i + 1;
               redir = 1'b1;
               if (ins[i][1:0] == 2'b00) begin
                  e_imj[i] = 1'b1;
                  tgt      = spc + jmp_disp(ins[i]);
               end else begin
                  // register jump falls through to the next slot
                  tgt = spc + 16'd1;
               end
            end
         end
         if ((i < stop) && branch_op(ins[i]))
            live = live + 1;
      end
      for (int i = 0; i < 4; i++) begin
         e_inst[i] = (i < stop) ? ins[i] : 16'h0;
      end
      e_full = m_hold || over;
      // next pc, mispredict first
      if (r.ctl[3] && r.ctl[1])
         nxt = r.rtgt;
      else if (r.ctl[5] || r.ctl[4])
         nxt = m_pc;
      else if (redir)
         nxt = tgt;
      else
         nxt = m_pc + 16'(stop);
      base = m_cnt;
      if (r.ctl[3]) begin
         base = base - (r.ctl[0] ? 2 : 1);
         if (base < 0)
            base = 0;
      end
      m_cnt = base + live;
      if (r.ctl[3])
         m_hold = 1'b0;
      else if (over)
         m_hold = 1'b1;
      m_flush = any_pred || (r.ctl[3] && r.ctl[1]);
      // counter training
      if (r.ctl[3]) begin
         idx = r.rpc[3:0];
         if (r.ctl[2] && (m_ctr[idx] != 2'd3))
            m_ctr[idx] = m_ctr[idx] + 2'd1;
         else if (!r.ctl[2] && (m_ctr[idx] != 2'd0))
            m_ctr[idx] = m_ctr[idx] - 2'd1;
      end
      m_pc = nxt;
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus table
   //////////////////////////////////////////////////////////////////////

   task automatic build_table();
      add_row(fill, fill, fill, fill, c_none, 16'h0, 16'h0);
      // imm jump in slot 1, then a register jump held and released
      add_row(fill, 16'hf040, 16'ha010, fill, c_none, 16'h0, 16'h0);
      add_row(fill, 16'hf001, fill, fill, c_jwait, 16'h0, 16'h0);
      add_row(fill, 16'hf001, fill, fill, c_none, 16'h0, 16'h0);
      // branch at 0x17, trained twice, seen again at 0x27
      add_row(16'ha008, fill, fill, fill, c_none, 16'h0, 16'h0);
      add_row(fill, fill, fill, fill, c_res | c_tkn, 16'h0017, 16'h0);
      add_row(fill, fill, fill, fill, c_res | c_tkn, 16'h0017, 16'h0);
      add_row(fill, fill, fill, fill, c_none, 16'h0, 16'h0);
      add_row(16'ha010, fill, fill, fill, c_none, 16'h0, 16'h0);
      add_row(fill, fill, fill, fill, c_res | c_tkn, 16'h0027, 16'h0);
      // three branches, hold until a resolve
      add_row(16'ha004, 16'ha004, 16'ha004, fill, c_none, 16'h0, 16'h0);
      add_row(fill, fill, fill, fill, c_none, 16'h0, 16'h0);
      add_row(fill, fill, fill, fill, c_none, 16'h0, 16'h0);
      add_row(fill, fill, fill, fill, c_res, 16'h003b, 16'h0);
      add_row(fill, fill, fill, fill, c_none, 16'h0, 16'h0);
      // both stalls
      add_row(16'ha004, fill, fill, fill, c_stall, 16'h0, 16'h0);
      add_row(16'hf040, fill, fill, fill, c_jwait, 16'h0, 16'h0);
      add_row(16'hf040, fill, fill, fill, c_res, 16'h003c, 16'h0);
      // mispredict dropping two branches
      add_row(16'ha004, 16'ha004, fill, fill, c_none, 16'h0, 16'h0);
      add_row(fill, fill, fill, fill, c_res | c_tkn | c_mis | c_two, 16'h0051, 16'h0080);
      add_row(fill, fill, 16'ha004, 16'ha004, c_none, 16'h0, 16'h0);
      // backward jump, then a third branch at slot 0
      add_row(fill, fill, fill, 16'hfff0, c_none, 16'h0, 16'h0);
      add_row(16'ha004, fill, fill, fill, c_none, 16'h0, 16'h0);
      add_row(fill, fill, fill, fill, c_res, 16'h0082, 16'h0);
      add_row(16'ha004, fill, fill, fill, c_none, 16'h0, 16'h0);
      add_row(fill, fill, fill, fill, c_none, 16'h0, 16'h0);
   endtask

   initial begin
      row_t             r;
      logic [3:0][15:0] ins;
      clk                = 1'b0;
      rst_n              = 1'b0;
      inst0              = 16'h0;
      inst1              = 16'h0;
      inst2              = 16'h0;
      inst3              = 16'h0;
      stall_fetch        = 1'b0;
      stall_for_jump     = 1'b0;
      resolve_valid      = 1'b0;
      resolve_taken      = 1'b0;
      resolve_mispredict = 1'b0;
      resolve_two        = 1'b0;
      resolve_pc         = 16'h0;
      resolve_target     = 16'h0;
      errors             = 0;
      checks             = 0;
      cycles             = 0;
      seed               = 32'h2464197d;
      build_table();
      cycle_limit = rows.size() * 4 + reset_cycles;
      m_pc    = 16'h0;
      m_cnt   = 0;
      m_hold  = 1'b0;
      m_flush = 1'b0;
      for (int e = 0; e < 16; e++) begin
         m_ctr[e] = 2'd1;
      end
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      foreach (rows[n]) begin
         // registered outputs settled since the last rising edge
         check_regs();
         r = rows[n];
         for (int k = 0; k < 4; k++) begin
            ins[k] = (r.inst[k] == fill) ? filler() : r.inst[k];
         end
         inst0              = ins[0];
         inst1              = ins[1];
         inst2              = ins[2];
         inst3              = ins[3];
         stall_fetch        = r.ctl[5];
         stall_for_jump     = r.ctl[4];
         resolve_valid      = r.ctl[3];
         resolve_taken      = r.ctl[2];
         resolve_mispredict = r.ctl[1];
         resolve_two        = r.ctl[0];
         resolve_pc         = r.rpc;
         resolve_target     = r.rtgt;
         #1;
         model_step(r, ins);
         compare("instruction0", instruction0, e_inst[0]);
         compare("instruction1", instruction1, e_inst[1]);
         compare("instruction2", instruction2, e_inst[2]);
         compare("instruction3", instruction3, e_inst[3]);
         compare("tkn_brnch", 16'(tkn_brnch), 16'(e_tkn));
         compare("is_im_jmp", 16'(is_im_jmp), 16'(e_imj));
         compare("brch_full", 16'(brch_full), 16'(e_full));
         @(negedge clk);
      end
      check_regs();
      $display("errors %0d of %0d checks", errors, checks);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

/* filelist.f */
verilog/fetch_pkg.sv
verilog/bpred_pkg.sv
verilog/fetch_bundle_if.sv
verilog/resolve_if.sv
verilog/bundle_filter.sv
verilog/branch_predictor.sv
verilog/fetch_pc_unit.sv
verilog/fetch_front_end.sv
sim/tb_fetch_front_end.sv

/* Makefile */
TOP = tb_fetch_front_end

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
